/* bench/fetchTb.sv */
// Testbench for the fetch subsystem
// Follows a fixed program through branches, jumps, SIIC and two fetch faults
// r7 is decremented on each fault so the second one leaves for the end loop
`default_nettype none

module fetchTb;
   timeunit 1ns;
   timeprecision 1ps;
   import fetchPkg::*;

   logic clk;
   logic reset;
   instrT prdata;
   logic pready;
   logic pslverr;
   regDataT rsData;
   logic psel;
   logic penable;
   pcT paddr;
   regAddrT rsAddr;
   logic retire;
   pcT retiredPc;
   instrT retiredInstr;
   pcT retiredNextPc;
   logic fetchFault;

   // Register file seen through the read port
   regDataT regs [8] = '{16'h0000, 16'h0005, 16'hfffd, 16'h0040,
                         16'h8000, 16'h0001, 16'h0030, 16'h0001};

   // Model state
   pcT expPc = resetVector;
   pcT modelEpc = '0;
   pcT expNext;
   logic expFault;
   int retireCount = 0;
   int loopCount = 0;
   int faultCount = 0;
   int siicCount = 0;

   // psel of the previous cycle, marks setup versus access
   logic prevPsel = 1'b0;

   assign rsData = regs[rsAddr];

   fetchTop fetchTop_i (
      .clk(clk), .reset(reset), .prdata(prdata), .pready(pready), .pslverr(pslverr),
      .rsData(rsData), .psel(psel), .penable(penable), .paddr(paddr), .rsAddr(rsAddr),
      .retire(retire), .retiredPc(retiredPc), .retiredInstr(retiredInstr),
      .retiredNextPc(retiredNextPc), .fetchFault(fetchFault)
   );

   progMemory progMemory_i (
      .clk(clk), .reset(reset), .psel(psel), .penable(penable), .paddr(paddr),
      .prdata(prdata), .pready(pready), .pslverr(pslverr)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Expected next PC of a non-faulting instruction
   function automatic pcT refNextPc(input pcT pc, input instrT ins, input regDataT r [8],
                                    input pcT savedEpc);
      pcT seqPc;
      pcT immOff;
      pcT dispOff;
      regDataT rs;
      pcT result;
      seqPc = pc + 16'd2;
      immOff = {{8{ins[7]}}, ins[7:0]};
      dispOff = {{5{ins[10]}}, ins[10:0]};
      rs = r[ins[10:8]];
      result = seqPc;
      case (ins[15:11])
         opSiic: result = 16'h0002;
         opRti: result = savedEpc;
         opJ: result = seqPc + dispOff;
         opJr: result = rs + immOff;
         opBeqz: if (rs == 16'h0000) result = seqPc + immOff;
         opBnez: if (rs != 16'h0000) result = seqPc + immOff;
         opBltz: if (rs[15]) result = seqPc + immOff;
         opBgez: if (!rs[15]) result = seqPc + immOff;
         default: result = seqPc;
      endcase
      return result;
   endfunction

   task automatic stopOnError();
      $display("*** FAILED ***");
      $fatal(1, "stopped at first error");
   endtask

   task automatic checkPc(input string name, input pcT got, input pcT exp);
      if (got !== exp) begin
         $display("error: %s expected %h got %h", name, exp, got);
         stopOnError();
      end
   endtask

   task automatic checkInstr(input string name, input instrT got, input instrT exp);
      if (got !== exp) begin
         $display("error: %s expected %h got %h", name, exp, got);
         stopOnError();
      end
   endtask

   task automatic checkRegAddr(input string name, input regAddrT got, input regAddrT exp);
      if (got !== exp) begin
         $display("error: %s expected %h got %h", name, exp, got);
         stopOnError();
      end
   endtask

   task automatic checkBit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("error: %s expected %h got %h", name, exp, got);
         stopOnError();
      end
   endtask

   // Comparison on every clock
   always @(posedge clk) begin
      if (reset) begin
         prevPsel = 1'b0;
      end else begin
         // First psel cycle is setup, later ones are access
         checkBit("penable", penable, psel && prevPsel);
         prevPsel = psel;
      end
      if (!reset && psel) begin
         // Address of the transfer is the PC of the next retirement
         checkPc("paddr", paddr, expPc);
      end
      if (!reset && retire) begin
         expFault = (expPc >= 16'h0050);
         // One instruction in flight, no transfer while retiring
         checkBit("psel", psel, 1'b0);
         checkPc("retiredPc", retiredPc, expPc);
         checkBit("fetchFault", fetchFault, expFault);
         if (expFault) begin
            expNext = 16'h0002;
            modelEpc = expPc;
            faultCount++;
            regs[7] <= regs[7] - 16'd1;
         end else begin
            checkInstr("retiredInstr", retiredInstr, progMemory_i.words[expPc[6:1]]);
            // Register index comes from instruction bits 10:8
            checkRegAddr("rsAddr", rsAddr, progMemory_i.words[expPc[6:1]][10:8]);
            expNext = refNextPc(expPc, progMemory_i.words[expPc[6:1]], regs, modelEpc);
            if (progMemory_i.words[expPc[6:1]][15:11] == opSiic) begin
               modelEpc = expPc + 16'd2;
               siicCount++;
            end
         end
         checkPc("retiredNextPc", retiredNextPc, expNext);
         if (expNext == expPc) begin
            loopCount++;
         end
         expPc = expNext;
         retireCount++;
         if (retireCount > 200) begin
            $display("program ran past its expected path");
            stopOnError();
         end
      end
   end

   initial begin
      int idleCycles;
      int lastCount;
      reset = 1'b1;
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      idleCycles = 0;
      lastCount = 0;
      // Each retirement must follow the previous one within the timeout
      while (loopCount < 10) begin
         @(negedge clk);
         if (retireCount != lastCount) begin
            lastCount = retireCount;
            idleCycles = 0;
         end else begin
            idleCycles++;
         end
         if (idleCycles > 40) begin
            $display("no retirement within 40 cycles");
            $display("*** FAILED ***");
            $fatal(1, "timeout waiting for retire");
         end
      end
      if (faultCount == 2 && siicCount == 1) begin
         $display("*** PASSED ***");
         $finish;
      end else begin
         $display("wrong event counts: %0d faults, %0d SIIC", faultCount, siicCount);
         $display("*** FAILED ***");
         $fatal(1, "program path incomplete");
      end
   end

endmodule

`default_nettype wire

/* bench/progMemory.sv */
// APB program memory model for the fetch testbench
// Holds a fixed 40-word program from address 0; higher addresses answer pslverr
// Each transfer gets 0 to 3 wait states from a seeded $random
// Error responses return a zero data word
`default_nettype none

module progMemory (
   input  logic            clk,
   input  logic            reset,
   input  logic            psel,
   input  logic            penable,
   input  fetchPkg::pcT    paddr,
   output fetchPkg::instrT prdata,
   output logic            pready,
   output logic            pslverr
);
   timeunit 1ns;
   timeprecision 1ps;
   import fetchPkg::*;

   instrT words [40];
   integer seed;
   logic [1:0] waitLeft;
   logic [1:0] draw;
   logic inRange;

   // Program ends at 0x004E
   assign inRange = (paddr < 16'h0050);

   // Register-test and JR format
   function automatic instrT packRegImm(input opcodeT op, input regAddrT rs, input immT imm);
      return {op, rs, imm};
   endfunction

   // J format
   function automatic instrT packDisp(input opcodeT op, input dispT disp);
      return {op, disp};
   endfunction

   initial begin
      seed = 32'h0b93b8e5;
      prdata = '0;
      pready = 1'b0;
      pslverr = 1'b0;
      waitLeft = 2'd0;
      // Unlisted words are sequential no-ops
      for (int i = 0; i < 40; i++) begin
         words[i] = '0;
      end
      // Reset vector skips the handler
      words[0] = packDisp(opJ, 11'h00c);
      // Handler: leave for the end loop once r7 goes negative, else return
      words[1] = packRegImm(opBltz, 3'd7, 8'h4a);
      words[2] = packRegImm(opRti, 3'd0, 8'h00);
      // Branches, taken and not taken
      words[7] = packRegImm(opBeqz, 3'd0, 8'h04);
      words[10] = packRegImm(opBeqz, 3'd1, 8'h08);
      words[11] = packRegImm(opBnez, 3'd1, 8'h02);
      words[13] = packRegImm(opBnez, 3'd0, 8'hf0);
      words[14] = packRegImm(opBltz, 3'd2, 8'h02);
      words[16] = packRegImm(opBltz, 3'd1, 8'hfc);
      words[17] = packRegImm(opBgez, 3'd4, 8'h02);
      words[18] = packRegImm(opBgez, 3'd0, 8'h04);
      // Forward jumps and a taken backward branch
      words[21] = packDisp(opJ, 11'h006);
      words[25] = packRegImm(opBnez, 3'd5, 8'hf8);
      words[23] = packDisp(opJ, 11'h006);
      // Register jumps, SIIC, backward J
      words[27] = packRegImm(opJr, 3'd3, 8'hfc);
      words[30] = packRegImm(opSiic, 3'd0, 8'h00);
      words[31] = packDisp(opJ, 11'h7f8);
      words[28] = packRegImm(opJr, 3'd6, 8'h1a);
      // Jump past the program end, then the closing self-loop
      words[37] = packDisp(opJ, 11'h040);
      words[39] = packDisp(opJ, 11'h7fe);
   end

   always @(posedge clk) begin
      if (reset) begin
         pready <= 1'b0;
         pslverr <= 1'b0;
         waitLeft <= 2'd0;
      end else if (psel && !penable) begin
         // Setup cycle, draw the wait states of this transfer
         draw = 2'($random(seed));
         waitLeft <= draw;
         pready <= (draw == 2'd0);
         prdata <= inRange ? words[paddr[6:1]] : '0;
         pslverr <= !inRange;
      end else if (psel && penable && !pready) begin
         waitLeft <= waitLeft - 2'd1;
         pready <= (waitLeft == 2'd1);
      end else begin
         pready <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* fetchTop.f */
src/fetchPkg.sv
src/pcAdder.sv
src/branchControl.sv
src/apbFetch.sv
src/fetchUnit.sv
src/fetchTop.sv
bench/progMemory.sv
bench/fetchTb.sv

/* runSim.sh */
#!/bin/sh
# Builds and runs the fetch testbench; exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
   --top-module fetchTb -f fetchTop.f -o fetchSim &&
./obj_dir/fetchSim ||
{ echo "simulation failed"; exit 1; }

/* src/apbFetch.sv */
// Read-only APB master for instruction fetch
// A request is taken only while idle; fetchStart is ignored during a transfer
// The setup cycle follows the fetchStart cycle, then one or more access cycles
// Data and error appear with the fetchDone pulse after the completing edge
`default_nettype none

module apbFetch (
   input  logic            clk,
   input  logic            reset,
   input  logic            fetchStart,
   input  fetchPkg::pcT    fetchAddr,
   input  fetchPkg::instrT prdata,
   input  logic            pready,
   input  logic            pslverr,
   output logic            psel,
   output logic            penable,
   output fetchPkg::pcT    paddr,
   output logic            fetchDone,
   output fetchPkg::instrT fetchData,
   output logic            fetchErr
);
   logic startReq;
   logic complete;

   // Idle request and completing access cycle
   assign startReq = !psel && fetchStart;
   assign complete = psel && penable && pready;

   // Phase control
   always_ff @(posedge clk) begin
      if (reset) begin
         psel <= 1'b0;
         penable <= 1'b0;
         fetchDone <= 1'b0;
         fetchErr <= 1'b0;
      end else begin
         fetchDone <= 1'b0;
         if (startReq) begin
            // Enter setup
            psel <= 1'b1;
         end else if (psel && !penable) begin
            // Setup always lasts one cycle
            penable <= 1'b1;
         end else if (complete) begin
            psel <= 1'b0;
            penable <= 1'b0;
            fetchDone <= 1'b1;
            // pslverr counts only in the completing cycle
            fetchErr <= pslverr;
         end
      end
   end

   // Address held from setup to completion
   always_ff @(posedge clk) begin
      if (startReq) begin
         paddr <= fetchAddr;
      end
   end

   // Read data capture
   always_ff @(posedge clk) begin
      if (complete) begin
         fetchData <= prdata;
      end
   end

   aEnableNeedsSel: assert property (@(posedge clk) disable iff (reset)
      penable |-> psel)
      else $error("apbFetch: penable without psel");

   // Waiting or setup cycles keep the address for the next cycle
   aAddrStable: assert property (@(posedge clk) disable iff (reset)
      (psel && !complete) |=> $stable(paddr))
      else $error("apbFetch: paddr changed during a transfer");

endmodule

`default_nettype wire

/* src/branchControl.sv */
// Opcode decode and register test for the next-PC path
// The register value must arrive combinationally from rsAddr
// J is routed through the relative path with the D-form offset
// JR target is Rs plus the sign-extended I-form immediate
`default_nettype none

module branchControl (
   input  fetchPkg::instrT   instr,
   input  fetchPkg::regDataT rsData,
   output fetchPkg::regAddrT rsAddr,
   output logic              seSel,
   output logic              branchTaken,
   output logic              jump,
   output fetchPkg::pcT      jumpValue,
   output logic              getSiic,
   output logic              getEpc
);
   import fetchPkg::*;

   opcodeT opcode;
   immT imm;
   regDataT immExt;
   logic rsZero;
   logic rsNeg;

   // Field extraction
   assign opcode = instr[15:11];
   assign imm = instr[7:0];
   assign rsAddr = instr[10:8];

   // Register condition flags
   assign rsZero = (rsData == '0);
   assign rsNeg = rsData[15];

   // Register jump target, used only for JR
   assign immExt = {{8{imm[7]}}, imm};
   assign jumpValue = rsData + immExt;

   always_comb begin
      seSel = 1'b0;
      branchTaken = 1'b0;
      jump = 1'b0;
      getSiic = 1'b0;
      getEpc = 1'b0;
      case (opcode)
         opBeqz: branchTaken = rsZero;
         opBnez: branchTaken = !rsZero;
         opBltz: branchTaken = rsNeg;
         opBgez: branchTaken = !rsNeg;
         opJ: begin
            // Always taken, 11-bit displacement
            seSel = 1'b1;
            branchTaken = 1'b1;
         end
         opJr: jump = 1'b1;
         opSiic: getSiic = 1'b1;
         opRti: getEpc = 1'b1;
         // Sequential for everything else
         default: ;
      endcase
   end

   // Register jump and relative path never compete
   always_comb begin
      assert (!(jump === 1'b1 && branchTaken === 1'b1))
         else $error("branchControl: jump and branchTaken both high");
   end

endmodule

`default_nettype wire

/* src/fetchPkg.sv */
// Shared types and constants of the instruction-fetch subsystem
// Instructions and addresses are single 16-bit words, so the PC steps by two
// Only the opcodes listed here change the flow; every other code is sequential
`default_nettype none

package fetchPkg;

   // Word-wide values
   typedef logic [15:0] pcT;
   typedef logic [15:0] instrT;
   typedef logic [15:0] regDataT;

   // Instruction fields
   typedef logic [4:0] opcodeT;    // Bits 15:11
   typedef logic [7:0] immT;       // I-form, bits 7:0
   typedef logic [10:0] dispT;     // D-form, bits 10:0
   typedef logic [2:0] regAddrT;   // Rs index, bits 10:8

   // Exception entry and return
   localparam opcodeT opSiic = 5'b00010;
   localparam opcodeT opRti = 5'b00011;

   // Unconditional jumps
   localparam opcodeT opJ = 5'b00100;
   localparam opcodeT opJr = 5'b00101;

   // Register-test branches
   localparam opcodeT opBeqz = 5'b01100;
   localparam opcodeT opBnez = 5'b01101;
   localparam opcodeT opBltz = 5'b01110;
   localparam opcodeT opBgez = 5'b01111;

   // Fixed addresses
   localparam pcT resetVector = 16'h0000;
   localparam pcT siicVector = 16'h0002;
   localparam pcT pcStep = 16'h0002;

   // Sequencer states
   typedef enum logic [1:0] {
      stSetup,
      stAccess,
      stExecute
   } fetchStateT;

endpackage

`default_nettype wire

/* src/fetchTop.sv */
// Fetch subsystem top level, wiring only
// Program memory is an APB slave outside; register reads are combinational
`default_nettype none

module fetchTop (
   input  logic              clk,
   input  logic              reset,
   input  fetchPkg::instrT   prdata,
   input  logic              pready,
   input  logic              pslverr,
   input  fetchPkg::regDataT rsData,
   output logic              psel,
   output logic              penable,
   output fetchPkg::pcT      paddr,
   output fetchPkg::regAddrT rsAddr,
   output logic              retire,
   output fetchPkg::pcT      retiredPc,
   output fetchPkg::instrT   retiredInstr,
   output fetchPkg::pcT      retiredNextPc,
   output logic              fetchFault
);
   import fetchPkg::*;

   // Sequencer to APB requester
   logic fetchStart;
   pcT fetchAddr;
   logic fetchDone;
   instrT fetchData;
   logic fetchErr;

   // Held state
   instrT curInstr;
   pcT curPc;
   pcT epc;

   // Next-PC path
   pcT nextPc;
   pcT pcPlus2;
   logic seSel;
   logic branchTaken;
   logic jump;
   pcT jumpValue;
   logic getSiic;
   logic getEpc;

   fetchUnit fetchUnit_i (
      .clk(clk), .reset(reset), .fetchDone(fetchDone), .fetchData(fetchData),
      .fetchErr(fetchErr), .nextPc(nextPc), .pcPlus2(pcPlus2), .getSiic(getSiic),
      .fetchStart(fetchStart), .fetchAddr(fetchAddr), .curInstr(curInstr),
      .curPc(curPc), .epc(epc), .retire(retire), .retiredPc(retiredPc),
      .retiredInstr(retiredInstr), .retiredNextPc(retiredNextPc),
      .fetchFault(fetchFault)
   );

   apbFetch apbFetch_i (
      .clk(clk), .reset(reset), .fetchStart(fetchStart), .fetchAddr(fetchAddr),
      .prdata(prdata), .pready(pready), .pslverr(pslverr), .psel(psel),
      .penable(penable), .paddr(paddr), .fetchDone(fetchDone),
      .fetchData(fetchData), .fetchErr(fetchErr)
   );

   branchControl branchControl_i (
      .instr(curInstr), .rsData(rsData), .rsAddr(rsAddr), .seSel(seSel),
      .branchTaken(branchTaken), .jump(jump), .jumpValue(jumpValue),
      .getSiic(getSiic), .getEpc(getEpc)
   );

   // Offsets come straight from the held instruction word
   pcAdder pcAdder_i (
      .basePC(curPc), .imm(curInstr[7:0]), .disp(curInstr[10:0]), .seSel(seSel),
      .branchTaken(branchTaken), .jump(jump), .getSiic(getSiic), .getEpc(getEpc),
      .jumpValue(jumpValue), .epcValue(epc), .nextPc(nextPc), .pcPlus2(pcPlus2)
   );

endmodule

`default_nettype wire

/* src/fetchUnit.sv */
// Fetch sequencer holding PC, EPC and the current instruction
// One instruction in flight; each takes 3 cycles plus wait states from setup
// The first fetch after reset has one extra cycle before its setup
// A fetch error retires as a fault, jumps to the SIIC vector, saves the PC
`default_nettype none

module fetchUnit (
   input  logic            clk,
   input  logic            reset,
   input  logic            fetchDone,
   input  fetchPkg::instrT fetchData,
   input  logic            fetchErr,
   input  fetchPkg::pcT    nextPc,
   input  fetchPkg::pcT    pcPlus2,
   input  logic            getSiic,
   output logic            fetchStart,
   output fetchPkg::pcT    fetchAddr,
   output fetchPkg::instrT curInstr,
   output fetchPkg::pcT    curPc,
   output fetchPkg::pcT    epc,
   output logic            retire,
   output fetchPkg::pcT    retiredPc,
   output fetchPkg::instrT retiredInstr,
   output fetchPkg::pcT    retiredNextPc,
   output logic            fetchFault
);
   import fetchPkg::*;

   fetchStateT state;
   pcT pc;
   pcT pcNext;
   logic bootFetch;
   logic faultHeld;

   // Fault overrides the decoded next PC
   assign pcNext = faultHeld ? siicVector : nextPc;

   // Next fetch is requested while the current one retires
   assign fetchStart = (state == stExecute) || (state == stSetup && bootFetch);
   assign fetchAddr = (state == stExecute) ? pcNext : pc;

   // Retire report
   assign curPc = pc;
   assign retire = (state == stExecute);
   assign retiredPc = pc;
   assign retiredInstr = curInstr;
   assign retiredNextPc = pcNext;
   assign fetchFault = retire && faultHeld;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= stSetup;
         bootFetch <= 1'b1;
         pc <= resetVector;
         epc <= '0;
         faultHeld <= 1'b0;
      end else begin
         bootFetch <= 1'b0;
         case (state)
            stSetup: begin
               // Boot cycle only issues the first request
               if (!bootFetch) begin
                  state <= stAccess;
               end
            end
            stAccess: begin
               // Stalls here through all wait states
               if (fetchDone) begin
                  faultHeld <= fetchErr;
                  state <= stExecute;
               end
            end
            stExecute: begin
               pc <= pcNext;
               if (faultHeld) begin
                  epc <= pc;
               end else if (getSiic) begin
                  epc <= pcPlus2;
               end
               state <= stSetup;
            end
            default: state <= stSetup;
         endcase
      end
   end

   // Instruction word of the transfer just finished
   always_ff @(posedge clk) begin
      if (state == stAccess && fetchDone) begin
         curInstr <= fetchData;
      end
   end

   // Retire directly follows the APB completion pulse
   aRetireAfterDone: assert property (@(posedge clk) disable iff (reset)
      retire |-> (state == stExecute) && $past(fetchDone))
      else $error("fetchUnit: retire outside stExecute or without fetchDone");

   aDoneWhileWaiting: assert property (@(posedge clk) disable iff (reset)
      fetchDone |-> state == stAccess)
      else $error("fetchUnit: fetchDone outside stAccess");

endmodule

`default_nettype wire

/* src/pcAdder.sv */
// Next-PC selection, purely combinational
// Select inputs are expected to come from one decoded opcode
// Priority is EPC, SIIC vector, jump target, branch target, PC+2
`default_nettype none

module pcAdder (
   input  fetchPkg::pcT   basePC,
   input  fetchPkg::immT  imm,
   input  fetchPkg::dispT disp,
   input  logic           seSel,
   input  logic           branchTaken,
   input  logic           jump,
   input  logic           getSiic,
   input  logic           getEpc,
   input  fetchPkg::pcT   jumpValue,
   input  fetchPkg::pcT   epcValue,
   output fetchPkg::pcT   nextPc,
   output fetchPkg::pcT   pcPlus2
);
   import fetchPkg::*;

   pcT immExt;
   pcT dispExt;
   pcT offset;
   pcT relTarget;

   // Sign extension of both offset forms
   assign immExt = {{8{imm[7]}}, imm};
   assign dispExt = {{5{disp[10]}}, disp};

   // D-form when seSel is high
   assign offset = seSel ? dispExt : immExt;

   // Relative targets are taken from the following instruction
   assign pcPlus2 = basePC + pcStep;
   assign relTarget = pcPlus2 + offset;

   always_comb begin
      if (getEpc) begin
         nextPc = epcValue;
      end else if (getSiic) begin
         nextPc = siicVector;
      end else if (jump) begin
         nextPc = jumpValue;
      end else if (branchTaken) begin
         nextPc = relTarget;
      end else begin
         nextPc = pcPlus2;
      end
   end

   // Decode upstream must never request entry and return together
   always_comb begin
      assert (!(getSiic === 1'b1 && getEpc === 1'b1))
         else $error("pcAdder: getSiic and getEpc both high");
   end

endmodule

`default_nettype wire
